//--- Bender.yml
package:
  name: sm83_bus_front

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sm83_pkg.sv
      - rtl/sm83_tstate.sv
      - rtl/sm83_mcycle_ctl.sv
      - rtl/sm83_io.sv
      - rtl/sm83_predecode.sv
      - rtl/sm83_bus_front.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/sm83_mem_model.sv
      - sim/tb_sm83_bus_front.sv

//--- rtl/sm83_bus_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_consts.svh"

module sm83_bus_front (
	input  logic                    clk,
	input  logic                    reset,
	input  sm83_pkg::mc_kind_t      mc_kind,
	input  logic [`SM83_ADDR_W-1:0] mc_addr,
	input  logic [`SM83_DATA_W-1:0] mc_wdata,
	input  logic [`SM83_DATA_W-1:0] ext_din,
	input  logic [`SM83_DATA_W-1:0] iena,
	output logic [`SM83_ADDR_W-1:0] addr,
	output logic [`SM83_DATA_W-1:0] ext_dout,
	output logic                    rd,
	output logic                    wr,
	output logic [`SM83_DATA_W-1:0] rdata,
	output logic [`SM83_DATA_W-1:0] opcode,
	output logic                    bank_cb,
	output logic                    t4,
	output logic [1:0]              op_x,
	output logic [2:0]              op_y,
	output logic [2:0]              op_z,
	output logic [1:0]              op_p,
	output logic                    op_q,
	output logic                    illegal
);

	// phases that stay inside the front end
	logic                    t1;
	logic                    t2;
	logic                    t3;
	// controller strobes into the bus block
	logic                    mread;
	logic                    mwrite;
	logic                    apin_we;
	logic [`SM83_ADDR_W-1:0] ain;
	logic                    dl_we;
	logic [`SM83_DATA_W-1:0] din;
	logic                    iena_sel;
	logic                    ctl_ir_we;
	logic                    ctl_ir_bank_we;
	logic                    ctl_ir_bank_cb_set;
	logic                    ctl_zero_data_oe;
	// predecoder feedback for the bank decision
	logic                    is_cb_prefix;

	// machine-cycle phase generator
	sm83_tstate u_tstate (
		.clk   (clk),
		.reset (reset),
		.t1    (t1),
		.t2    (t2),
		.t3    (t3),
		.t4    (t4)
	);

	// request sampling and strobe generation
	sm83_mcycle_ctl u_mcycle_ctl (
		.clk                (clk),
		.reset              (reset),
		.t4                 (t4),
		.mc_kind            (mc_kind),
		.mc_addr            (mc_addr),
		.mc_wdata           (mc_wdata),
		.rd                 (rd),
		.bank_cb            (bank_cb),
		.is_cb_prefix       (is_cb_prefix),
		.mread              (mread),
		.mwrite             (mwrite),
		.apin_we            (apin_we),
		.ain                (ain),
		.dl_we              (dl_we),
		.din                (din),
		.iena_sel           (iena_sel),
		.ctl_ir_we          (ctl_ir_we),
		.ctl_ir_bank_we     (ctl_ir_bank_we),
		.ctl_ir_bank_cb_set (ctl_ir_bank_cb_set),
		.ctl_zero_data_oe   (ctl_zero_data_oe)
	);

	// pins, data latch and instruction register
	// dout is the read data seen by the core
	sm83_io u_io (
		.clk                (clk),
		.reset              (reset),
		.t1                 (t1),
		.t2                 (t2),
		.t3                 (t3),
		.t4                 (t4),
		.mread              (mread),
		.mwrite             (mwrite),
		.aout               (addr),
		.ain                (ain),
		.dout               (rdata),
		.din                (din),
		.ext_dout           (ext_dout),
		.ext_din            (ext_din),
		.apin_we            (apin_we),
		.dl_we              (dl_we),
		.rd                 (rd),
		.wr                 (wr),
		.opcode             (opcode),
		.bank_cb            (bank_cb),
		.iena               (iena),
		.iena_sel           (iena_sel),
		.ctl_ir_we          (ctl_ir_we),
		.ctl_ir_bank_we     (ctl_ir_bank_we),
		.ctl_ir_bank_cb_set (ctl_ir_bank_cb_set),
		.ctl_zero_data_oe   (ctl_zero_data_oe)
	);

	// opcode field split and prefix/illegal flags
	sm83_predecode u_predecode (
		.opcode       (opcode),
		.bank_cb      (bank_cb),
		.op_x         (op_x),
		.op_y         (op_y),
		.op_z         (op_z),
		.op_p         (op_p),
		.op_q         (op_q),
		.is_cb_prefix (is_cb_prefix),
		.illegal      (illegal)
	);

endmodule

`default_nettype wire

//--- rtl/sm83_consts.svh
`ifndef SM83_CONSTS_SVH
`define SM83_CONSTS_SVH

// external address bus width
`define SM83_ADDR_W 16

// external data bus and opcode width
`define SM83_DATA_W 8

// prefix byte that switches decode to the CB bank
`define SM83_CB_PREFIX 8'hCB

// interrupt-enable register sits at the top of the map
// reads there return the IE value, not the bus
`define SM83_IE_ADDR 16'hFFFF

// unused main-bank opcodes, real silicon locks up on them
// kept as a comma list so it drops straight into an inside set
`define SM83_ILLEGAL_LIST \
	8'hD3, 8'hDB, 8'hDD, \
	8'hE3, 8'hE4, 8'hEB, \
	8'hEC, 8'hED, 8'hF4, \
	8'hFC, 8'hFD

`endif

//--- rtl/sm83_io.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_consts.svh"

module sm83_io (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    t1,
	input  logic                    t2,
	input  logic                    t3,
	input  logic                    t4,
	input  logic                    mread,
	input  logic                    mwrite,
	output logic [`SM83_ADDR_W-1:0] aout,
	input  logic [`SM83_ADDR_W-1:0] ain,
	output logic [`SM83_DATA_W-1:0] dout,
	input  logic [`SM83_DATA_W-1:0] din,
	output logic [`SM83_DATA_W-1:0] ext_dout,
	input  logic [`SM83_DATA_W-1:0] ext_din,
	input  logic                    apin_we,
	input  logic                    dl_we,
	output logic                    rd,
	output logic                    wr,
	output logic [`SM83_DATA_W-1:0] opcode,
	output logic                    bank_cb,
	input  logic [`SM83_DATA_W-1:0] iena,
	input  logic                    iena_sel,
	input  logic                    ctl_ir_we,
	input  logic                    ctl_ir_bank_we,
	input  logic                    ctl_ir_bank_cb_set,
	input  logic                    ctl_zero_data_oe
);

	// inside a machine cycle, between the boundaries
	logic                    mid_cycle;
	// data latch, drives the pins during a write
	logic [`SM83_DATA_W-1:0] data;
	// value arriving at the read T4
	logic [`SM83_DATA_W-1:0] data_t4;
	// instruction register
	logic [`SM83_DATA_W-1:0] opcode_r;
	// read completes in this clock
	logic                    rd_end;

	assign mid_cycle = t1 | t2 | t3;
	assign rd_end    = rd & t4;

	// rd and wr levels
	// reloaded at each boundary, held through T1..T3
	always_ff @(posedge clk) begin
		if (reset) begin
			rd <= 1'b0;
			wr <= 1'b0;
		end else if (t4) begin
			rd <= mread;
			wr <= mwrite;
		end else if (mid_cycle) begin
			rd <= rd | mread;
			wr <= wr | mwrite;
		end
	end

	// address pins
	always_ff @(posedge clk) begin
		// upper byte relaxes to zero after every machine cycle
		if (t4)
			aout[`SM83_ADDR_W-1:8] <= '0;
		// a new address wins over the clearing
		if (apin_we)
			aout <= ain;
	end

	// read source: IE register, the pins, or zero on intack
	always_comb begin
		if (ctl_zero_data_oe)
			data_t4 = '0;
		else if (iena_sel)
			data_t4 = iena;
		else
			data_t4 = ext_din;
	end

	// data latch
	always_ff @(posedge clk) begin
		if (dl_we)
			data <= din;
		else if (rd_end)
			data <= data_t4;
		else if (ctl_zero_data_oe)
			data <= '0;
	end

	// read data bypasses the latch in its T4
	assign dout     = rd_end ? data_t4 : data;
	assign ext_dout = data;

	// instruction register and bank flag
	always_ff @(posedge clk) begin
		if (reset) begin
			opcode_r <= '0;
			bank_cb  <= 1'b0;
		end else begin
			if (ctl_ir_we)
				opcode_r <= data_t4;
			if (ctl_ir_bank_we)
				bank_cb <= ctl_ir_bank_cb_set;
		end
	end

	// write-through so the new opcode is visible in the fetch T4
	assign opcode = ctl_ir_we ? data_t4 : opcode_r;

endmodule

`default_nettype wire

//--- rtl/sm83_mcycle_ctl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_consts.svh"

module sm83_mcycle_ctl (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    t4,
	input  sm83_pkg::mc_kind_t      mc_kind,
	input  logic [`SM83_ADDR_W-1:0] mc_addr,
	input  logic [`SM83_DATA_W-1:0] mc_wdata,
	input  logic                    rd,
	input  logic                    bank_cb,
	input  logic                    is_cb_prefix,
	output logic                    mread,
	output logic                    mwrite,
	output logic                    apin_we,
	output logic [`SM83_ADDR_W-1:0] ain,
	output logic                    dl_we,
	output logic [`SM83_DATA_W-1:0] din,
	output logic                    iena_sel,
	output logic                    ctl_ir_we,
	output logic                    ctl_ir_bank_we,
	output logic                    ctl_ir_bank_cb_set,
	output logic                    ctl_zero_data_oe
);

	import sm83_pkg::*;

	// kind of the machine cycle currently on the bus
	mc_kind_t cur_kind;
	// current cycle addresses the IE register
	logic     ie_hit;
	// ending T4 of a cycle that loads the instruction register
	logic     ir_end;

	// request decode, only while sampling at T4
	always_comb begin
		mread   = 1'b0;
		mwrite  = 1'b0;
		apin_we = 1'b0;
		dl_we   = 1'b0;
		if (t4) begin
			case (mc_kind)
				MC_FETCH, MC_READ, MC_INTACK: begin
					mread   = 1'b1;
					apin_we = 1'b1;
				end
				MC_WRITE: begin
					mwrite  = 1'b1;
					apin_we = 1'b1;
					// write data goes to the latch with the address
					dl_we   = 1'b1;
				end
				default: begin
					// idle, and the unused encodings
					mread = 1'b0;
				end
			endcase
		end
	end

	// address and write data pass straight to the bus block
	// the enables above decide when they are taken
	assign ain = mc_addr;
	assign din = mc_wdata;

	// remember what was requested for the coming machine cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			cur_kind <= MC_IDLE;
			ie_hit   <= 1'b0;
		end else if (t4) begin
			cur_kind <= mc_kind;
			ie_hit   <= (mc_kind != MC_IDLE) && (mc_addr == `SM83_IE_ADDR);
		end
	end

	// read data comes from IE instead of the pins
	assign iena_sel = ie_hit;

	// intack keeps the data path at zero for the whole cycle
	assign ctl_zero_data_oe = (cur_kind == MC_INTACK);

	// rd only stays up through T4 of a read-type cycle
	assign ir_end = t4 && rd && ((cur_kind == MC_FETCH) || (cur_kind == MC_INTACK));

	assign ctl_ir_we = ir_end;

	// set the bank on a main-bank CB, clear it on any later fetch
	// is_cb_prefix is already masked by the bank in the predecoder
	assign ctl_ir_bank_we     = ir_end && (is_cb_prefix || bank_cb);
	assign ctl_ir_bank_cb_set = is_cb_prefix;

endmodule

`default_nettype wire

//--- rtl/sm83_pkg.sv
`default_nettype none

package sm83_pkg;

	// kind of bus transfer requested for the next machine cycle
	typedef enum logic [2:0] {
		// no transfer, address lines relax
		MC_IDLE   = 3'd0,
		// opcode read into the instruction register
		MC_FETCH  = 3'd1,
		// plain data read
		MC_READ   = 3'd2,
		// data write
		MC_WRITE  = 3'd3,
		// interrupt acknowledge, bus data forced to zero
		MC_INTACK = 3'd4
	} mc_kind_t;

	// one opcode byte, two decode views over the same bits
	typedef union packed {
		// x/y/z split
		// cb bank: x = operation, y = bit index, z = register
		struct packed {
			logic [1:0] x;
			logic [2:0] y;
			logic [2:0] z;
		} xyz;
		// x/p/q/z split
		// main bank: p picks the register pair, q the direction
		struct packed {
			logic [1:0] x;
			logic [1:0] p;
			logic       q;
			logic [2:0] z;
		} xpqz;
	} opcode_u;

endpackage

`default_nettype wire

//--- rtl/sm83_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_consts.svh"

module sm83_predecode (
	input  logic [`SM83_DATA_W-1:0] opcode,
	input  logic                    bank_cb,
	output logic [1:0]              op_x,
	output logic [2:0]              op_y,
	output logic [2:0]              op_z,
	output logic [1:0]              op_p,
	output logic                    op_q,
	output logic                    is_cb_prefix,
	output logic                    illegal
);

	import sm83_pkg::*;

	// the byte seen through both decode views
	opcode_u op;
	// byte is one of the unused main-bank codes
	logic    in_illegal_set;
	// byte equals the prefix value
	logic    is_cb_byte;

	assign op = opcode;

	// x/y/z fields, shared by both banks
	// cb bank reads them as operation, bit, register
	assign op_x = op.xyz.x;
	assign op_y = op.xyz.y;
	assign op_z = op.xyz.z;

	// register pair select and its direction bit
	// y is p followed by q, so both views overlap bit for bit
	assign op_p = op.xpqz.p;
	assign op_q = op.xpqz.q;

	assign is_cb_byte     = (opcode == `SM83_CB_PREFIX);
	assign in_illegal_set = opcode inside {`SM83_ILLEGAL_LIST};

	// every CB-bank byte is a valid operation
	// so both flags only apply to the main bank
	assign is_cb_prefix = !bank_cb && is_cb_byte;
	assign illegal      = !bank_cb && in_illegal_set;

endmodule

`default_nettype wire

//--- rtl/sm83_tstate.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_tstate (
	input  logic clk,
	input  logic reset,
	output logic t1,
	output logic t2,
	output logic t3,
	output logic t4
);

	// one-hot phase, bit 0 is T1 and bit 3 is T4
	logic [3:0] phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			// park in T4 so the first clock out of reset is a boundary
			phase <= 4'b1000;
		end else begin
			// T4 wraps around to T1
			phase <= {phase[2:0], phase[3]};
		end
	end

	// exactly one phase high per clock
	assign t1 = phase[0];
	assign t2 = phase[1];
	assign t3 = phase[2];
	assign t4 = phase[3];

endmodule

`default_nettype wire

//--- sim/sm83_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_consts.svh"

module sm83_mem_model (
	input  logic                    clk,
	input  logic                    t4,
	input  logic [`SM83_ADDR_W-1:0] addr,
	input  logic                    rd,
	input  logic                    wr,
	input  logic [`SM83_DATA_W-1:0] wdata,
	output logic [`SM83_DATA_W-1:0] rdata
);

	// full 64 KiB map, one byte per address
	logic [`SM83_DATA_W-1:0] mem [0:(1 << `SM83_ADDR_W) - 1];

	// byte at the pins while rd is up
	// bus reads as zero when nobody is reading
	assign rdata = rd ? mem[addr] : '0;

	// write lands on the last T4 of the write cycle
	// address and data are still on the pins there
	always @(posedge clk) begin
		if (wr && t4)
			mem[addr] <= wdata;
	end

	// preload hook, used before the bus starts moving
	task automatic write_byte(input logic [15:0] a, input logic [7:0] v);
		mem[a] = v;
	endtask

endmodule

`default_nettype wire

//--- sim/tb_sm83_bus_front.sv
`timescale 1ns/1ps
`default_nettype none

`include "sm83_consts.svh"

module tb_sm83_bus_front;

	import sm83_pkg::*;

	// request plus what the front end must show at its ending T4
	typedef struct packed {
		mc_kind_t   kind;
		logic [15:0] addr;
		logic [7:0] wdata;
		logic [7:0] iena;
		logic [7:0] exp_rdata;
		logic [7:0] exp_op;
		logic       exp_bank;
		logic       exp_ill;
		logic [7:0] exp_hi;
	} row_t;

	logic clk;
	logic reset;
	mc_kind_t mc_kind;
	logic [15:0] mc_addr;
	logic [7:0] mc_wdata;
	logic [7:0] ext_din;
	logic [7:0] iena;
	logic [15:0] addr;
	logic [7:0] ext_dout;
	logic rd;
	logic wr;
	logic [7:0] rdata;
	logic [7:0] opcode;
	logic bank_cb;
	logic t4;
	logic [1:0] op_x;
	logic [2:0] op_y;
	logic [2:0] op_z;
	logic [1:0] op_p;
	logic op_q;
	logic illegal;

	// stimulus table and the reference copy of memory
	row_t rows [0:31];
	int n_rows;
	logic [7:0] model_mem [0:65535];
	int errors;
	int checks;
	bit timed_out;
	int k;
	int seed_val;

	sm83_bus_front dut0 (
		.clk(clk), .reset(reset), .mc_kind(mc_kind), .mc_addr(mc_addr),
		.mc_wdata(mc_wdata), .ext_din(ext_din), .iena(iena), .addr(addr),
		.ext_dout(ext_dout), .rd(rd), .wr(wr), .rdata(rdata), .opcode(opcode),
		.bank_cb(bank_cb), .t4(t4), .op_x(op_x), .op_y(op_y), .op_z(op_z),
		.op_p(op_p), .op_q(op_q), .illegal(illegal)
	);

	sm83_mem_model mem0 (
		.clk(clk), .t4(t4), .addr(addr), .rd(rd), .wr(wr),
		.wdata(ext_dout), .rdata(ext_din)
	);

	// 4 ns period
	always #2 clk = ~clk;

	task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// same byte into the memory model and the reference copy
	task automatic place_byte(input logic [15:0] a, input logic [7:0] v);
		model_mem[a] = v;
		mem0.write_byte(a, v);
	endtask

	task automatic fill_memory();
		logic [31:0] r;
		for (int a = 0; a < 65536; a++) begin
			r = $urandom;
			place_byte(a[15:0], r[7:0]);
		end
		// CB prefix, a CB-bank op, an illegal code and a plain op
		place_byte(16'h0100, 8'hcb);
		place_byte(16'h0101, 8'h7c);
		place_byte(16'h0102, 8'hd3);
		place_byte(16'h0103, 8'h7a);
	endtask

	task automatic add_row(input mc_kind_t kind, input logic [15:0] a, input logic [7:0] wd,
			input logic [7:0] ie, input logic [7:0] exp_rdata, input logic [7:0] exp_op,
			input logic exp_bank, input logic exp_ill, input logic [7:0] exp_hi);
		row_t row;
		row.kind = kind;
		row.addr = a;
		row.wdata = wd;
		row.iena = ie;
		row.exp_rdata = exp_rdata;
		row.exp_op = exp_op;
		row.exp_bank = exp_bank;
		row.exp_ill = exp_ill;
		row.exp_hi = exp_hi;
		// later reads of this address see the new byte
		if (kind == MC_WRITE)
			model_mem[a] = wd;
		rows[n_rows] = row;
		n_rows++;
	endtask

	task automatic build_table();
		// kind, addr, wdata, iena, rdata, opcode, bank_cb during cycle, illegal, addr high
		add_row(MC_READ, 16'h8a3c, 8'h00, 8'h00, model_mem[16'h8a3c], 8'h00, 0, 0, 8'h8a);
		// idle ignores its own address and keeps the low byte of the last one
		add_row(MC_IDLE, 16'h5a96, 8'h00, 8'h00, model_mem[16'h8a3c], 8'h00, 0, 0, 8'h00);
		add_row(MC_WRITE, 16'h4455, 8'ha5, 8'h00, 8'ha5, 8'h00, 0, 0, 8'h44);
		add_row(MC_READ, 16'h4455, 8'h00, 8'h00, model_mem[16'h4455], 8'h00, 0, 0, 8'h44);
		// IE register instead of the bus
		add_row(MC_READ, 16'hffff, 8'h00, 8'h1f, 8'h1f, 8'h00, 0, 0, 8'hff);
		add_row(MC_FETCH, 16'h0103, 8'h00, 8'h00, 8'h7a, 8'h7a, 0, 0, 8'h01);
		add_row(MC_FETCH, 16'h0102, 8'h00, 8'h00, 8'hd3, 8'hd3, 0, 1, 8'h01);
		add_row(MC_FETCH, 16'h0100, 8'h00, 8'h00, 8'hcb, 8'hcb, 0, 0, 8'h01);
		// D3 in the CB bank is a valid op
		add_row(MC_FETCH, 16'h0102, 8'h00, 8'h00, 8'hd3, 8'hd3, 1, 0, 8'h01);
		add_row(MC_FETCH, 16'h0100, 8'h00, 8'h00, 8'hcb, 8'hcb, 0, 0, 8'h01);
		// second CB is an op, so the bank drops again
		add_row(MC_FETCH, 16'h0100, 8'h00, 8'h00, 8'hcb, 8'hcb, 1, 0, 8'h01);
		add_row(MC_FETCH, 16'h0101, 8'h00, 8'h00, 8'h7c, 8'h7c, 0, 0, 8'h01);
		add_row(MC_INTACK, 16'h0040, 8'h00, 8'h00, 8'h00, 8'h00, 0, 0, 8'h00);
		add_row(MC_WRITE, 16'h0200, 8'h3c, 8'h00, 8'h3c, 8'h00, 0, 0, 8'h02);
		add_row(MC_READ, 16'hc71e, 8'h00, 8'h00, model_mem[16'hc71e], 8'h00, 0, 0, 8'hc7);
		add_row(MC_IDLE, 16'h3b01, 8'h00, 8'h00, model_mem[16'hc71e], 8'h00, 0, 0, 8'h00);
	endtask

	// follow one machine cycle up to its T4
	// the cycle on the bus belongs to the row driven two rounds earlier
	task automatic watch_cycle(input int idx);
		int n;
		row_t row;
		logic exp_rd;
		logic exp_wr;
		logic exp_bank;
		row = '0;
		exp_rd = 1'b0;
		exp_wr = 1'b0;
		exp_bank = 1'b0;
		if (idx >= 2) begin
			row = rows[idx - 2];
			exp_rd = (row.kind == MC_FETCH) || (row.kind == MC_READ) || (row.kind == MC_INTACK);
			exp_wr = (row.kind == MC_WRITE);
			exp_bank = row.exp_bank;
		end
		n = 0;
		do begin
			@(negedge clk);
			n++;
			// every machine cycle ends on its fourth clock
			expect_eq("t4", t4, n == 4);
			expect_eq("rd", rd, exp_rd);
			expect_eq("wr", wr, exp_wr);
			expect_eq("bank_cb", bank_cb, exp_bank);
			if (exp_wr)
				expect_eq("ext_dout", ext_dout, row.wdata);
		end while (!t4 && n < 8);
		if (!t4) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: no T4 seen within 8 clocks before row %0d", idx);
		end
	endtask

	// results at the ending T4
	task automatic check_row_end(input int r);
		row_t row;
		logic [7:0] exp_lo;
		row = rows[r];
		exp_lo = row.addr[7:0];
		// an idle cycle leaves the low byte of the previous address on the pins
		if (row.kind == MC_IDLE && r > 0)
			exp_lo = rows[r - 1].addr[7:0];
		expect_eq("rdata", rdata, row.exp_rdata);
		expect_eq("opcode", opcode, row.exp_op);
		expect_eq("illegal", illegal, row.exp_ill);
		expect_eq("addr_hi", addr[15:8], row.exp_hi);
		expect_eq("addr_lo", addr[7:0], exp_lo);
		// field split through the xyz and xpqz views
		expect_eq("op_x", op_x, row.exp_op[7:6]);
		expect_eq("op_y", op_y, row.exp_op[5:3]);
		expect_eq("op_z", op_z, row.exp_op[2:0]);
		expect_eq("op_p", op_p, row.exp_op[5:4]);
		expect_eq("op_q", op_q, row.exp_op[3]);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		mc_kind = MC_IDLE;
		mc_addr = '0;
		mc_wdata = '0;
		iena = '0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		n_rows = 0;
		seed_val = $urandom(57);
		fill_memory();
		build_table();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		// bus quiet right out of reset
		@(negedge clk);
		expect_eq("rd", rd, 1'b0);
		expect_eq("wr", wr, 1'b0);
		expect_eq("bank_cb", bank_cb, 1'b0);
		expect_eq("opcode", opcode, 8'h00);
		// drive at each sampling edge and check two rounds later
		for (k = 0; k < n_rows + 2 && !timed_out; k++) begin
			watch_cycle(k);
			if (!timed_out) begin
				if (k >= 2)
					check_row_end(k - 2);
				@(posedge clk);
				if (k < n_rows) begin
					mc_kind <= rows[k].kind;
					mc_addr <= rows[k].addr;
					mc_wdata <= rows[k].wdata;
				end else begin
					mc_kind <= MC_IDLE;
				end
				// IE value lines up with the bus cycle of the previous row
				if (k >= 1 && k <= n_rows)
					iena <= rows[k - 1].iena;
			end
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sm83_bus_front.f
+incdir+rtl
rtl/sm83_pkg.sv
rtl/sm83_tstate.sv
rtl/sm83_mcycle_ctl.sv
rtl/sm83_io.sv
rtl/sm83_predecode.sv
rtl/sm83_bus_front.sv
sim/sm83_mem_model.sv
sim/tb_sm83_bus_front.sv
